/* logic/scaler_pkg.sv */
package scaler_pkg;

  ////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////

  localparam int NUM_CHANNELS = 8;
  // slot 0 carries the reference clock counter
  localparam int NUM_SLOTS    = NUM_CHANNELS + 1;
  localparam int COUNT_W      = 32;
  localparam int SLOT_W       = 4;
  localparam int EXTEND_W     = 5;
  localparam int CREDIT_W     = 3;
  localparam int MAX_CREDITS  = 4;

  ////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////

  typedef logic [COUNT_W-1:0]      count_t;
  typedef logic [SLOT_W-1:0]       slot_t;
  typedef logic [EXTEND_W-1:0]     extend_t;
  typedef logic [CREDIT_W-1:0]     credit_t;
  typedef logic [NUM_CHANNELS-1:0] hit_vec_t;
  typedef logic [NUM_SLOTS-1:0]    slot_vec_t;

  // static configuration that a control register would normally hold
  typedef struct packed {
    logic    stop_counting_on_busy;
    logic    disable_external_latch;
    extend_t busy_extend;
  } scaler_cfg_t;

  // strobes shared by every counter slot
  typedef struct packed {
    logic clear;
    logic latch;
  } counter_ctl_t;

  // one frame word where last marks the final slot
  typedef struct packed {
    slot_t  slot;
    count_t count;
    logic   last;
  } scaler_word_t;

  typedef enum logic [1:0] {
    IDLE,
    SEND,
    WAIT_CREDIT
  } readout_state_t;

endpackage

/* logic/scaler_front.sv */
`timescale 1ns/100ps

module scaler_front (
  input  logic                     CLK200,
  input  logic                     tdc_reset_start,
  input  scaler_pkg::hit_vec_t     i_hits,
  input  logic                     i_nim_latch,
  input  logic                     i_sw_latch,
  input  logic                     i_counter_reset,
  input  scaler_pkg::scaler_cfg_t  i_cfg,
  input  logic                     i_frame_active,
  output scaler_pkg::slot_vec_t    o_count_en,
  output scaler_pkg::counter_ctl_t o_ctl,
  output logic                     o_latch_done
);

  logic                 nim_q;
  logic                 nim_q2;
  logic                 nim_edge;
  scaler_pkg::extend_t  extend_cnt;
  logic                 raw_busy;
  logic                 busy;
  scaler_pkg::hit_vec_t hit_q;
  logic                 latch_block;
  logic                 latch_req;

  ////////////////////////////////////////////////////////////
  // NIM latch input, leading edge and busy window
  ////////////////////////////////////////////////////////////

  assign nim_edge = nim_q & ~nim_q2;

  // busy while the input is high, then busy_extend more cycles
  assign raw_busy = nim_q | (extend_cnt != '0);

  ////////////////////////////////////////////////////////////
  // latch merge
  ////////////////////////////////////////////////////////////

  // hold off new latches from the strobe until the frame is sent,
  // otherwise the frozen values could move under the readout
  assign latch_block = i_frame_active | o_ctl.latch | o_latch_done;
  assign latch_req   = (i_sw_latch | (nim_edge & ~i_cfg.disable_external_latch))
                       & ~latch_block;

  always_ff @(posedge CLK200) begin
    if (tdc_reset_start) begin
      nim_q        <= 1'b0;
      nim_q2       <= 1'b0;
      extend_cnt   <= '0;
      busy         <= 1'b0;
      hit_q        <= '0;
      o_ctl        <= '0;
      o_latch_done <= 1'b0;
    end else begin
      nim_q  <= i_nim_latch;
      nim_q2 <= nim_q;
      // reload while high, run down after the falling edge
      if (nim_q) begin
        extend_cnt <= i_cfg.busy_extend;
      end else if (extend_cnt != '0) begin
        extend_cnt <= extend_cnt - scaler_pkg::extend_t'(1);
      end
      busy         <= i_cfg.stop_counting_on_busy & raw_busy;
      hit_q        <= i_hits;
      o_ctl.clear  <= i_counter_reset;
      o_ctl.latch  <= latch_req;
      // counters hold the new values one cycle after the strobe
      o_latch_done <= o_ctl.latch;
    end
  end

  ////////////////////////////////////////////////////////////
  // count enables with the clock in slot 0
  ////////////////////////////////////////////////////////////

  assign o_count_en = {hit_q & ~{scaler_pkg::NUM_CHANNELS{busy}}, ~busy};

endmodule

/* logic/channel_counter.sv */
`timescale 1ns/100ps

module channel_counter (
  input  logic                     CLK200,
  input  logic                     tdc_reset_start,
  input  logic                     i_count_en,
  input  scaler_pkg::counter_ctl_t i_ctl,
  output scaler_pkg::count_t       o_latched
);

  scaler_pkg::count_t running;

  // free running count, wraps at full width
  always_ff @(posedge CLK200) begin
    if (tdc_reset_start) begin
      running <= '0;
    end else if (i_ctl.clear) begin
      running <= '0;
    end else if (i_count_en) begin
      running <= running + scaler_pkg::count_t'(1);
    end
  end

  // snapshot for readout
  // takes the count as it stood before this edge
  always_ff @(posedge CLK200) begin
    if (i_ctl.latch) begin
      o_latched <= running;
    end
  end

endmodule

/* logic/scaler_readout.sv */
`timescale 1ns/100ps

module scaler_readout (
  input  logic                     CLK200,
  input  logic                     tdc_reset_start,
  input  scaler_pkg::count_t       i_latched [scaler_pkg::NUM_SLOTS],
  input  logic                     i_latch_done,
  input  logic                     i_credit,
  output scaler_pkg::scaler_word_t o_word,
  output logic                     o_word_valid,
  output logic                     o_frame_active
);

  scaler_pkg::readout_state_t state;
  scaler_pkg::slot_t          slot_idx;
  scaler_pkg::credit_t        credit_cnt;
  logic                       last_slot;

  ////////////////////////////////////////////////////////////
  // word output
  ////////////////////////////////////////////////////////////

  assign last_slot = (slot_idx == scaler_pkg::slot_t'(scaler_pkg::NUM_SLOTS - 1));

  // a word goes out only while a credit is held
  assign o_word_valid   = (state == scaler_pkg::SEND) && (credit_cnt != '0);
  assign o_frame_active = (state != scaler_pkg::IDLE);

  assign o_word = '{
    slot:  slot_idx,
    count: i_latched[slot_idx],
    last:  last_slot
  };

  ////////////////////////////////////////////////////////////
  // credits
  ////////////////////////////////////////////////////////////

  // one credit back per i_credit pulse, one spent per word
  always_ff @(posedge CLK200) begin
    if (tdc_reset_start) begin
      credit_cnt <= scaler_pkg::credit_t'(scaler_pkg::MAX_CREDITS);
    end else begin
      credit_cnt <= credit_cnt
                    + scaler_pkg::credit_t'(i_credit)
                    - scaler_pkg::credit_t'(o_word_valid);
    end
  end

  ////////////////////////////////////////////////////////////
  // frame sequencer
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK200) begin
    if (tdc_reset_start) begin
      state    <= scaler_pkg::IDLE;
      slot_idx <= '0;
    end else begin
      case (state)
        scaler_pkg::IDLE: begin
          if (i_latch_done) begin
            state    <= scaler_pkg::SEND;
            slot_idx <= '0;
          end
        end
        scaler_pkg::SEND: begin
          if (credit_cnt == '0) begin
            // keep slot_idx, resume from the same slot
            state <= scaler_pkg::WAIT_CREDIT;
          end else if (last_slot) begin
            state <= scaler_pkg::IDLE;
          end else begin
            slot_idx <= slot_idx + scaler_pkg::slot_t'(1);
          end
        end
        scaler_pkg::WAIT_CREDIT: begin
          if (credit_cnt != '0) begin
            state <= scaler_pkg::SEND;
          end
        end
        default: begin
          state <= scaler_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

/* logic/nim_scaler_top.sv */
`timescale 1ns/100ps

module nim_scaler_top (
  input  logic                     CLK200,
  input  logic                     tdc_reset_start,
  input  scaler_pkg::hit_vec_t     i_hits,
  input  logic                     i_nim_latch,
  input  logic                     i_sw_latch,
  input  logic                     i_counter_reset,
  input  scaler_pkg::scaler_cfg_t  i_cfg,
  input  logic                     i_credit,
  output scaler_pkg::scaler_word_t o_word,
  output logic                     o_word_valid
);

  scaler_pkg::slot_vec_t    count_en;
  scaler_pkg::counter_ctl_t ctl;
  scaler_pkg::count_t       latched [scaler_pkg::NUM_SLOTS];
  logic                     latch_done;
  logic                     frame_active;

  ////////////////////////////////////////////////////////////
  // edge, busy and strobe generation
  ////////////////////////////////////////////////////////////

  scaler_front u_front (
    .CLK200          (CLK200),
    .tdc_reset_start (tdc_reset_start),
    .i_hits          (i_hits),
    .i_nim_latch     (i_nim_latch),
    .i_sw_latch      (i_sw_latch),
    .i_counter_reset (i_counter_reset),
    .i_cfg           (i_cfg),
    .i_frame_active  (frame_active),
    .o_count_en      (count_en),
    .o_ctl           (ctl),
    .o_latch_done    (latch_done)
  );

  // slot 0 is the clock counter, slots 1.. the hit channels
  for (genvar s = 0; s < scaler_pkg::NUM_SLOTS; s++) begin : g_slot
    channel_counter u_counter (
      .CLK200          (CLK200),
      .tdc_reset_start (tdc_reset_start),
      .i_count_en      (count_en[s]),
      .i_ctl           (ctl),
      .o_latched       (latched[s])
    );
  end

  ////////////////////////////////////////////////////////////
  // frame output
  ////////////////////////////////////////////////////////////

  scaler_readout u_readout (
    .CLK200          (CLK200),
    .tdc_reset_start (tdc_reset_start),
    .i_latched       (latched),
    .i_latch_done    (latch_done),
    .i_credit        (i_credit),
    .o_word          (o_word),
    .o_word_valid    (o_word_valid),
    .o_frame_active  (frame_active)
  );

endmodule

/* testbench/nim_scaler_assertions.sv */
`timescale 1ns/100ps

module nim_scaler_assertions (
  input logic                       CLK200,
  input logic                       tdc_reset_start,
  input scaler_pkg::readout_state_t state,
  input scaler_pkg::slot_t          slot_idx,
  input scaler_pkg::credit_t        credit_cnt,
  input logic                       i_credit,
  input logic                       o_word_valid
);

  scaler_pkg::credit_t in_flight;
  scaler_pkg::slot_t   next_slot;

  // words sent and not yet paid back by the consumer
  always_ff @(posedge CLK200) begin
    if (tdc_reset_start) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight
                   + scaler_pkg::credit_t'(o_word_valid)
                   - scaler_pkg::credit_t'(i_credit);
    end
  end

  // slot the next word of the frame must carry
  always_ff @(posedge CLK200) begin
    if (tdc_reset_start) begin
      next_slot <= '0;
    end else if (state == scaler_pkg::IDLE) begin
      next_slot <= '0;
    end else if (o_word_valid) begin
      next_slot <= next_slot + scaler_pkg::slot_t'(1);
    end
  end

  a_credit_max: assert property (@(posedge CLK200) disable iff (tdc_reset_start)
    credit_cnt <= scaler_pkg::credit_t'(scaler_pkg::MAX_CREDITS))
    else $error("credit count %0d above the limit", credit_cnt);

  a_valid_needs_credit: assert property (@(posedge CLK200) disable iff (tdc_reset_start)
    o_word_valid |-> in_flight < scaler_pkg::credit_t'(scaler_pkg::MAX_CREDITS))
    else $error("word sent with no credit left");

  // frames start at slot 0 and step by one, also across credit waits
  a_slot_step: assert property (@(posedge CLK200) disable iff (tdc_reset_start)
    o_word_valid |-> slot_idx == next_slot)
    else $error("slot %0d sent where slot %0d was due", slot_idx, next_slot);

endmodule

/* testbench/tb_nim_scaler.sv */
`timescale 1ns/100ps

module tb_nim_scaler;

  logic                     CLK200;
  logic                     tdc_reset_start;
  scaler_pkg::hit_vec_t     i_hits;
  logic                     i_nim_latch;
  logic                     i_sw_latch;
  logic                     i_counter_reset;
  scaler_pkg::scaler_cfg_t  i_cfg;
  logic                     i_credit = 1'b0;
  scaler_pkg::scaler_word_t o_word;
  logic                     o_word_valid;

  // consumer side
  scaler_pkg::scaler_word_t rx_words [$];
  int                       words_rx = 0;
  int                       credits_given = 0;
  logic                     hold_credits = 1'b0;
  logic [1:0]               credit_delay = 2'd0;
  logic [31:0]              cons_seed = 32'h8df6;

  // stimulus and reference model
  logic [31:0]              stim_seed = 32'h8df6;
  scaler_pkg::count_t       exp_hits [scaler_pkg::NUM_CHANNELS];
  int                       exp_clock = 0;
  int                       err_cnt = 0;
  int                       check_cnt = 0;
  int                       test_cnt = 0;

  nim_scaler_top dut_i (
    .CLK200          (CLK200),
    .tdc_reset_start (tdc_reset_start),
    .i_hits          (i_hits),
    .i_nim_latch     (i_nim_latch),
    .i_sw_latch      (i_sw_latch),
    .i_counter_reset (i_counter_reset),
    .i_cfg           (i_cfg),
    .i_credit        (i_credit),
    .o_word          (o_word),
    .o_word_valid    (o_word_valid)
  );

  bind scaler_readout nim_scaler_assertions u_assertions (
    .CLK200          (CLK200),
    .tdc_reset_start (tdc_reset_start),
    .state           (state),
    .slot_idx        (slot_idx),
    .credit_cnt      (credit_cnt),
    .i_credit        (i_credit),
    .o_word_valid    (o_word_valid)
  );

  initial begin
    CLK200 = 1'b0;
    forever #10 CLK200 = ~CLK200;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic bit near_edge(input int i, input int pos);
    return (i >= pos - 2) && (i <= pos + 2);
  endfunction

  ////////////////////////////////////////////////////////////
  // consumer takes words mid cycle and returns credits after a random delay
  ////////////////////////////////////////////////////////////

  always @(negedge CLK200) begin
    if (o_word_valid === 1'b1) begin
      rx_words.push_back(o_word);
      words_rx++;
    end
  end

  always @(posedge CLK200) begin
    if (i_credit) begin
      i_credit <= 1'b0;
    end else if (!hold_credits && words_rx > credits_given) begin
      if (credit_delay == 2'd0) begin
        i_credit      <= 1'b1;
        credits_given <= credits_given + 1;
        cons_seed = lcg_next(cons_seed);
        credit_delay  <= cons_seed[17:16];
      end else begin
        credit_delay <= credit_delay - 2'd1;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // checks and reporting
  ////////////////////////////////////////////////////////////

  task automatic compare_count(input string name, input scaler_pkg::count_t exp,
                               input scaler_pkg::count_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("error %s: expected count %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic compare_slot(input string name, input scaler_pkg::slot_t exp,
                              input scaler_pkg::slot_t act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("error %s: expected slot %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic compare_last(input string name, input logic exp, input logic act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("error %s: expected last %0b, actual %0b", name, exp, act);
    end
  endtask

  task automatic report_failure(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic finish_test(input string name, input int first_err);
    test_cnt++;
    if (err_cnt == first_err) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - first_err);
    end
  endtask

  task automatic wait_words(input int n, input int limit, output bit ok);
    ok = 1'b0;
    for (int t = 0; t < limit && !ok; t++) begin
      @(posedge CLK200);
      ok = (rx_words.size() >= n);
    end
  endtask

  task automatic wait_credits_back(input string name);
    int t;
    t = 0;
    while (credits_given != words_rx && t < 200) begin
      @(posedge CLK200);
      t++;
    end
    if (credits_given != words_rx) begin
      report_failure($sformatf("%s: consumer credits still outstanding", name));
    end
    repeat (2) @(posedge CLK200);
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus window and frame check
  ////////////////////////////////////////////////////////////

  // counter reset, len cycles of hits, then a software or NIM latch
  // nb > 0 puts a NIM pulse over window cycles nb .. ne-1
  task automatic run_window(input int len, input int nb, input int ne, input bit ext);
    scaler_pkg::hit_vec_t h;
    int                   e;
    bit                   blocked;
    foreach (exp_hits[ch]) exp_hits[ch] = '0;
    exp_clock = 0;
    @(posedge CLK200);
    e = int'(i_cfg.busy_extend);
    i_counter_reset <= 1'b1;
    i_hits          <= '0;
    for (int i = 1; i <= len; i++) begin
      @(posedge CLK200);
      i_counter_reset <= 1'b0;
      stim_seed = lcg_next(stim_seed);
      h = stim_seed[31:24];
      // keep hits away from both busy edges
      if (nb > 0 && (near_edge(i, nb + 1) || near_edge(i, ne + e))) begin
        h = '0;
      end
      i_hits      <= h;
      i_nim_latch <= (nb > 0) && (i >= nb) && (i < ne);
      blocked = i_cfg.stop_counting_on_busy && (nb > 0) && (i > nb) && (i <= ne + e);
      for (int ch = 0; ch < scaler_pkg::NUM_CHANNELS; ch++) begin
        if (!blocked) exp_hits[ch] = exp_hits[ch] + scaler_pkg::count_t'(h[ch]);
      end
      if (!blocked) exp_clock++;
    end
    @(posedge CLK200);
    i_counter_reset <= 1'b0;
    i_hits          <= '0;
    i_nim_latch     <= ext;
    i_sw_latch      <= !ext;
    @(posedge CLK200);
    i_sw_latch <= 1'b0;
    if (ext) repeat (2) @(posedge CLK200);
    i_nim_latch <= 1'b0;
  endtask

  task automatic check_frame(input string name, input bit check_clk,
                             input scaler_pkg::count_t exp_clk);
    bit                       ok;
    scaler_pkg::scaler_word_t w;
    wait_words(scaler_pkg::NUM_SLOTS, 300, ok);
    if (!ok) begin
      report_failure($sformatf("%s: frame incomplete at timeout, %0d words seen",
                               name, rx_words.size()));
    end else begin
      for (int s = 0; s < scaler_pkg::NUM_SLOTS; s++) begin
        w = rx_words[s];
        compare_slot(name, scaler_pkg::slot_t'(s), w.slot);
        compare_last(name, s == scaler_pkg::NUM_SLOTS - 1, w.last);
        if (s > 0) begin
          compare_count(name, exp_hits[s-1], w.count);
        end else if (check_clk) begin
          compare_count(name, exp_clk, w.count);
        end
      end
    end
    rx_words.delete();
    wait_credits_back(name);
  endtask

  initial begin
    int first_err;
    bit ok;
    tdc_reset_start <= 1'b1;
    i_hits          <= '0;
    i_nim_latch     <= 1'b0;
    i_sw_latch      <= 1'b0;
    i_counter_reset <= 1'b0;
    i_cfg           <= '0;
    repeat (2) @(posedge CLK200);
    tdc_reset_start <= 1'b0;

    first_err = err_cnt;
    run_window(80, 0, 0, 1'b0);
    check_frame("basic_count", 1'b0, '0);
    finish_test("basic_count", first_err);

    first_err = err_cnt;
    run_window(37, 0, 0, 1'b0);
    check_frame("clock_slot", 1'b1, scaler_pkg::count_t'(37));
    finish_test("clock_slot", first_err);

    // NIM pulse only opens the busy window here
    first_err = err_cnt;
    i_cfg <= '{stop_counting_on_busy: 1'b1, disable_external_latch: 1'b1,
               busy_extend: 5'd6};
    run_window(60, 15, 30, 1'b0);
    check_frame("busy_gated", 1'b1, scaler_pkg::count_t'(exp_clock));
    finish_test("busy_gated", first_err);

    first_err = err_cnt;
    i_cfg.stop_counting_on_busy <= 1'b0;
    run_window(60, 15, 30, 1'b0);
    check_frame("busy_ungated", 1'b1, scaler_pkg::count_t'(60));
    finish_test("busy_ungated", first_err);

    // NIM latch acts one cycle later than a software latch
    first_err = err_cnt;
    i_cfg <= '0;
    run_window(50, 0, 0, 1'b1);
    check_frame("external_latch", 1'b1, scaler_pkg::count_t'(51));
    i_cfg.disable_external_latch <= 1'b1;
    @(posedge CLK200);
    i_nim_latch <= 1'b1;
    repeat (3) @(posedge CLK200);
    i_nim_latch <= 1'b0;
    wait_words(1, 60, ok);
    if (ok) report_failure("external_latch: frame sent with the external latch disabled");
    rx_words.delete();
    wait_credits_back("external_latch");
    finish_test("external_latch", first_err);

    // withhold credits, keep counting, then release
    first_err = err_cnt;
    i_cfg        <= '0;
    hold_credits <= 1'b1;
    run_window(40, 0, 0, 1'b0);
    wait_words(scaler_pkg::MAX_CREDITS, 100, ok);
    if (!ok) report_failure("credit_flow: first words of the frame never arrived");
    repeat (30) begin
      @(posedge CLK200);
      stim_seed = lcg_next(stim_seed);
      i_hits <= stim_seed[31:24];
    end
    @(posedge CLK200);
    i_hits <= '0;
    compare_count("credit_flow", scaler_pkg::count_t'(scaler_pkg::MAX_CREDITS),
                  scaler_pkg::count_t'(rx_words.size()));
    hold_credits <= 1'b0;
    check_frame("credit_flow", 1'b1, scaler_pkg::count_t'(40));
    finish_test("credit_flow", first_err);

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* files.f */
logic/scaler_pkg.sv
logic/scaler_front.sv
logic/channel_counter.sv
logic/scaler_readout.sv
logic/nim_scaler_top.sv
testbench/nim_scaler_assertions.sv
testbench/tb_nim_scaler.sv

/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
	  -f files.f --top-module tb_nim_scaler -Mdir obj_dir

run: compile
	./obj_dir/Vtb_nim_scaler | tee sim.log
	grep -q '^\*\* PASS \*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log
